//--- source/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// Number of joint TLB entries and the width of an index into them.
`define TLB_ENTRIES 16
`define TLB_INDEX_W 4

// Address space identifier width.
`define ASID_W      8

// A VPN2 names a pair of 4 KB pages, so it spans vaddr bits 31..13.
`define VPN2_W      19

// Physical frame number width for 4 KB frames.
`define PFN_W       20

`endif

//--- source/mmu_pkg.sv
`include "mmu_defs.svh"

package mmu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] paddr_t;

	typedef logic [`ASID_W-1:0]      asid_t;
	typedef logic [`VPN2_W-1:0]      vpn2_t;
	typedef logic [`PFN_W-1:0]       pfn_t;
	typedef logic [`TLB_INDEX_W-1:0] tlb_index_t;

	// CP0 registers reachable through the register access port.
	typedef enum logic [2:0] {
		CP0_INDEX     = 3'd0,
		CP0_RANDOM    = 3'd1,
		CP0_ENTRY_LO0 = 3'd2,
		CP0_ENTRY_LO1 = 3'd3,
		CP0_ENTRY_HI  = 3'd4
	} cp0_sel_t;

endpackage

//--- source/tlb.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb
	import mmu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  asid_t      asid,
	input  vaddr_t     inst_vpn,
	input  vaddr_t     data_vpn,

	input  logic       tlb_we,
	input  tlb_index_t tlb_windex,
	input  vpn2_t      tlb_wvpn2,
	input  asid_t      tlb_wasid,
	input  logic       tlb_wg,
	input  pfn_t       tlb_wpfn0,
	input  logic       tlb_wd0,
	input  logic       tlb_wv0,
	input  pfn_t       tlb_wpfn1,
	input  logic       tlb_wd1,
	input  logic       tlb_wv1,

	input  tlb_index_t tlb_rindex,
	input  vpn2_t      probe_vpn2,
	input  asid_t      probe_asid,

	output logic       inst_hit,
	output logic       inst_valid,
	output pfn_t       inst_pfn,
	output logic       data_hit,
	output logic       data_valid,
	output logic       data_dirty,
	output pfn_t       data_pfn,

	output vpn2_t      tlb_rvpn2,
	output asid_t      tlb_rasid,
	output logic       tlb_rg,
	output pfn_t       tlb_rpfn0,
	output logic       tlb_rd0,
	output logic       tlb_rv0,
	output pfn_t       tlb_rpfn1,
	output logic       tlb_rd1,
	output logic       tlb_rv1,

	output logic       probe_hit,
	output tlb_index_t probe_index
);

	vpn2_t ent_vpn2 [`TLB_ENTRIES];
	asid_t ent_asid [`TLB_ENTRIES];
	pfn_t  ent_pfn0 [`TLB_ENTRIES];
	pfn_t  ent_pfn1 [`TLB_ENTRIES];
	logic [`TLB_ENTRIES-1:0] ent_g;
	logic [`TLB_ENTRIES-1:0] ent_d0;
	logic [`TLB_ENTRIES-1:0] ent_v0;
	logic [`TLB_ENTRIES-1:0] ent_d1;
	logic [`TLB_ENTRIES-1:0] ent_v1;

	logic [`TLB_ENTRIES-1:0] inst_match;
	logic [`TLB_ENTRIES-1:0] data_match;
	logic [`TLB_ENTRIES-1:0] probe_match;
	tlb_index_t inst_index;
	tlb_index_t data_index;

	// Matches are one-hot when software keeps entries unique, so an OR encoder is enough.
	function automatic tlb_index_t encode(input logic [`TLB_ENTRIES-1:0] m);
		tlb_index_t idx;
		idx = '0;
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			if (m[i])
				idx = idx | tlb_index_t'(i);
		end
		return idx;
	endfunction

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `TLB_ENTRIES; i++)
			begin
				ent_vpn2[i] <= '0;
				ent_asid[i] <= '0;
				ent_pfn0[i] <= '0;
				ent_pfn1[i] <= '0;
				ent_g[i]    <= 1'b0;
				ent_d0[i]   <= 1'b0;
				ent_v0[i]   <= 1'b0;
				ent_d1[i]   <= 1'b0;
				ent_v1[i]   <= 1'b0;
			end
		end
		else if (tlb_we)
		begin
			ent_vpn2[tlb_windex] <= tlb_wvpn2;
			ent_asid[tlb_windex] <= tlb_wasid;
			ent_pfn0[tlb_windex] <= tlb_wpfn0;
			ent_pfn1[tlb_windex] <= tlb_wpfn1;
			ent_g[tlb_windex]    <= tlb_wg;
			ent_d0[tlb_windex]   <= tlb_wd0;
			ent_v0[tlb_windex]   <= tlb_wv0;
			ent_d1[tlb_windex]   <= tlb_wd1;
			ent_v1[tlb_windex]   <= tlb_wv1;
		end
	end

	// The two lookups and the probe share the same compare against every entry.
	always_comb
	begin
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			inst_match[i]  = (ent_vpn2[i] == inst_vpn[31:13]) && (ent_g[i] || ent_asid[i] == asid);
			data_match[i]  = (ent_vpn2[i] == data_vpn[31:13]) && (ent_g[i] || ent_asid[i] == asid);
			probe_match[i] = (ent_vpn2[i] == probe_vpn2) && (ent_g[i] || ent_asid[i] == probe_asid);
		end
	end

	assign inst_index = encode(inst_match);
	assign data_index = encode(data_match);

	assign inst_hit   = |inst_match;
	assign inst_pfn   = inst_vpn[12] ? ent_pfn1[inst_index] : ent_pfn0[inst_index]; // Odd page.
	assign inst_valid = inst_hit && (inst_vpn[12] ? ent_v1[inst_index] : ent_v0[inst_index]);

	assign data_hit   = |data_match;
	assign data_pfn   = data_vpn[12] ? ent_pfn1[data_index] : ent_pfn0[data_index];
	assign data_valid = data_hit && (data_vpn[12] ? ent_v1[data_index] : ent_v0[data_index]);
	assign data_dirty = data_hit && (data_vpn[12] ? ent_d1[data_index] : ent_d0[data_index]);

	assign tlb_rvpn2 = ent_vpn2[tlb_rindex];
	assign tlb_rasid = ent_asid[tlb_rindex];
	assign tlb_rg    = ent_g[tlb_rindex];
	assign tlb_rpfn0 = ent_pfn0[tlb_rindex];
	assign tlb_rd0   = ent_d0[tlb_rindex];
	assign tlb_rv0   = ent_v0[tlb_rindex];
	assign tlb_rpfn1 = ent_pfn1[tlb_rindex];
	assign tlb_rd1   = ent_d1[tlb_rindex];
	assign tlb_rv1   = ent_v1[tlb_rindex];

	assign probe_hit   = |probe_match;
	assign probe_index = encode(probe_match);

endmodule

//--- source/mmu.sv
`timescale 1ns/1ps

module mmu
	import mmu_pkg::*;
#(
	parameter bit mmu_enabled = 1'b1
)
(
	input  logic       clk,
	input  logic       arst_n,
	input  asid_t      asid,
	input  logic       is_user_mode,
	input  vaddr_t     inst_vaddr,
	input  vaddr_t     data_vaddr,

	input  logic       tlb_we,
	input  tlb_index_t tlb_windex,
	input  vpn2_t      tlb_wvpn2,
	input  asid_t      tlb_wasid,
	input  logic       tlb_wg,
	input  pfn_t       tlb_wpfn0,
	input  logic       tlb_wd0,
	input  logic       tlb_wv0,
	input  pfn_t       tlb_wpfn1,
	input  logic       tlb_wd1,
	input  logic       tlb_wv1,

	input  tlb_index_t tlb_rindex,
	output vpn2_t      tlb_rvpn2,
	output asid_t      tlb_rasid,
	output logic       tlb_rg,
	output pfn_t       tlb_rpfn0,
	output logic       tlb_rd0,
	output logic       tlb_rv0,
	output pfn_t       tlb_rpfn1,
	output logic       tlb_rd1,
	output logic       tlb_rv1,

	input  vpn2_t      probe_vpn2,
	input  asid_t      probe_asid,
	output logic       probe_hit,
	output tlb_index_t probe_index,

	output paddr_t     inst_phy_addr,
	output logic       inst_miss,
	output logic       inst_invalid,
	output logic       inst_illegal,
	output paddr_t     data_phy_addr,
	output logic       data_miss,
	output logic       data_invalid,
	output logic       data_illegal,
	output logic       data_dirty
);

	logic inst_hit;
	logic inst_valid;
	pfn_t inst_pfn;
	logic data_hit;
	logic data_valid;
	logic data_tlb_dirty;
	pfn_t data_pfn;

	tlb u_tlb (
		.clk,
		.arst_n,
		.asid,
		.inst_vpn   (inst_vaddr),
		.data_vpn   (data_vaddr),
		.tlb_we,
		.tlb_windex,
		.tlb_wvpn2,
		.tlb_wasid,
		.tlb_wg,
		.tlb_wpfn0,
		.tlb_wd0,
		.tlb_wv0,
		.tlb_wpfn1,
		.tlb_wd1,
		.tlb_wv1,
		.tlb_rindex,
		.probe_vpn2,
		.probe_asid,
		.inst_hit,
		.inst_valid,
		.inst_pfn,
		.data_hit,
		.data_valid,
		.data_dirty (data_tlb_dirty),
		.data_pfn,
		.tlb_rvpn2,
		.tlb_rasid,
		.tlb_rg,
		.tlb_rpfn0,
		.tlb_rd0,
		.tlb_rv0,
		.tlb_rpfn1,
		.tlb_rd1,
		.tlb_rv1,
		.probe_hit,
		.probe_index
	);

	// useg, kseg2 and kseg3 go through the TLB.
	function automatic logic is_mapped(input vaddr_t va);
		return !va[31] || (va[31:30] == 2'b11);
	endfunction

	generate
		if (mmu_enabled)
		begin : g_enabled
			logic inst_mapped;
			logic data_mapped;

			assign inst_mapped = is_mapped(inst_vaddr);
			assign data_mapped = is_mapped(data_vaddr);

			assign inst_miss     = inst_mapped && !inst_hit;
			assign inst_illegal  = inst_mapped && !inst_valid; // A miss is never valid.
			assign inst_invalid  = is_user_mode && inst_vaddr[31];
			assign inst_phy_addr = inst_mapped ? {inst_pfn, inst_vaddr[11:0]}
			                                   : {3'b000, inst_vaddr[28:0]};

			assign data_miss     = data_mapped && !data_hit;
			assign data_illegal  = data_mapped && !data_valid;
			assign data_invalid  = is_user_mode && data_vaddr[31];
			assign data_dirty    = !data_mapped || data_tlb_dirty; // Set means writable.
			assign data_phy_addr = data_mapped ? {data_pfn, data_vaddr[11:0]}
			                                   : {3'b000, data_vaddr[28:0]};
		end
		else
		begin : g_disabled
			assign inst_phy_addr = inst_vaddr;
			assign inst_miss     = 1'b0;
			assign inst_invalid  = 1'b0;
			assign inst_illegal  = 1'b0;
			assign data_phy_addr = data_vaddr;
			assign data_miss     = 1'b0;
			assign data_invalid  = 1'b0;
			assign data_illegal  = 1'b0;
			assign data_dirty    = 1'b1;
		end
	endgenerate

endmodule

//--- source/tlb_regs.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_regs
	import mmu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,

	input  logic       cp0_we,
	input  cp0_sel_t   cp0_sel,
	input  word_t      cp0_wdata,
	output word_t      cp0_rdata,

	input  logic       tlbr,
	input  logic       tlbwi,
	input  logic       tlbwr,
	input  logic       tlbp,

	output asid_t      asid,

	output logic       tlb_we,
	output tlb_index_t tlb_windex,
	output vpn2_t      tlb_wvpn2,
	output asid_t      tlb_wasid,
	output logic       tlb_wg,
	output pfn_t       tlb_wpfn0,
	output logic       tlb_wd0,
	output logic       tlb_wv0,
	output pfn_t       tlb_wpfn1,
	output logic       tlb_wd1,
	output logic       tlb_wv1,

	output tlb_index_t tlb_rindex,
	input  vpn2_t      tlb_rvpn2,
	input  asid_t      tlb_rasid,
	input  logic       tlb_rg,
	input  pfn_t       tlb_rpfn0,
	input  logic       tlb_rd0,
	input  logic       tlb_rv0,
	input  pfn_t       tlb_rpfn1,
	input  logic       tlb_rd1,
	input  logic       tlb_rv1,

	output vpn2_t      probe_vpn2,
	output asid_t      probe_asid,
	input  logic       probe_hit,
	input  tlb_index_t probe_index
);

	logic       index_p;
	tlb_index_t index_idx;
	tlb_index_t random_q;
	vpn2_t      hi_vpn2;
	asid_t      hi_asid;
	pfn_t       lo0_pfn;
	logic [2:0] lo0_dvg; // D, V and G.
	pfn_t       lo1_pfn;
	logic [2:0] lo1_dvg;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			random_q <= tlb_index_t'(`TLB_ENTRIES - 1);
		else if (random_q == '0)
			random_q <= tlb_index_t'(`TLB_ENTRIES - 1);
		else
			random_q <= random_q - 1'b1;
	end

	// The probe-fail flag is only changed by TLBP.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			index_p   <= 1'b0;
			index_idx <= '0;
		end
		else if (tlbp)
		begin
			index_p <= !probe_hit;
			if (probe_hit)
				index_idx <= probe_index;
		end
		else if (cp0_we && cp0_sel == CP0_INDEX)
			index_idx <= cp0_wdata[`TLB_INDEX_W-1:0];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hi_vpn2 <= '0;
			hi_asid <= '0;
			lo0_pfn <= '0;
			lo0_dvg <= '0;
			lo1_pfn <= '0;
			lo1_dvg <= '0;
		end
		else if (tlbr)
		begin
			hi_vpn2 <= tlb_rvpn2;
			hi_asid <= tlb_rasid;
			lo0_pfn <= tlb_rpfn0;
			lo0_dvg <= {tlb_rd0, tlb_rv0, tlb_rg};
			lo1_pfn <= tlb_rpfn1;
			lo1_dvg <= {tlb_rd1, tlb_rv1, tlb_rg};
		end
		else if (cp0_we)
		begin
			case (cp0_sel)
				CP0_ENTRY_HI:
				begin
					hi_vpn2 <= cp0_wdata[31 -: `VPN2_W];
					hi_asid <= cp0_wdata[`ASID_W-1:0];
				end
				CP0_ENTRY_LO0:
				begin
					lo0_pfn <= cp0_wdata[6 +: `PFN_W];
					lo0_dvg <= cp0_wdata[2:0];
				end
				CP0_ENTRY_LO1:
				begin
					lo1_pfn <= cp0_wdata[6 +: `PFN_W];
					lo1_dvg <= cp0_wdata[2:0];
				end
				default: ; // Index is handled above and Random ignores writes.
			endcase
		end
	end

	always_comb
	begin
		cp0_rdata = '0;
		case (cp0_sel)
			CP0_INDEX:
			begin
				cp0_rdata[31]                = index_p;
				cp0_rdata[`TLB_INDEX_W-1:0]  = index_idx;
			end
			CP0_RANDOM:
				cp0_rdata[`TLB_INDEX_W-1:0] = random_q;
			CP0_ENTRY_LO0:
			begin
				cp0_rdata[6 +: `PFN_W] = lo0_pfn;
				cp0_rdata[2:0]         = lo0_dvg;
			end
			CP0_ENTRY_LO1:
			begin
				cp0_rdata[6 +: `PFN_W] = lo1_pfn;
				cp0_rdata[2:0]         = lo1_dvg;
			end
			CP0_ENTRY_HI:
			begin
				cp0_rdata[31 -: `VPN2_W] = hi_vpn2;
				cp0_rdata[`ASID_W-1:0]   = hi_asid;
			end
			default: cp0_rdata = '0;
		endcase
	end

	assign asid       = hi_asid;
	assign probe_vpn2 = hi_vpn2;
	assign probe_asid = hi_asid;

	assign tlb_we     = tlbwi || tlbwr;
	assign tlb_windex = tlbwr ? random_q : index_idx;
	assign tlb_rindex = index_idx;

	// An entry is global only if both halves carry G.
	assign tlb_wvpn2 = hi_vpn2;
	assign tlb_wasid = hi_asid;
	assign tlb_wg    = lo0_dvg[0] && lo1_dvg[0];
	assign tlb_wpfn0 = lo0_pfn;
	assign tlb_wd0   = lo0_dvg[2];
	assign tlb_wv0   = lo0_dvg[1];
	assign tlb_wpfn1 = lo1_pfn;
	assign tlb_wd1   = lo1_dvg[2];
	assign tlb_wv1   = lo1_dvg[1];

endmodule

//--- source/mmu_top.sv
`timescale 1ns/1ps

module mmu_top
	import mmu_pkg::*;
#(
	parameter bit mmu_enabled = 1'b1
)
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     is_user_mode,
	input  vaddr_t   inst_vaddr,
	input  vaddr_t   data_vaddr,

	input  logic     cp0_we,
	input  cp0_sel_t cp0_sel,
	input  word_t    cp0_wdata,
	output word_t    cp0_rdata,

	input  logic     tlbr,
	input  logic     tlbwi,
	input  logic     tlbwr,
	input  logic     tlbp,

	output paddr_t   inst_phy_addr,
	output logic     inst_miss,
	output logic     inst_invalid,
	output logic     inst_illegal,
	output paddr_t   data_phy_addr,
	output logic     data_miss,
	output logic     data_invalid,
	output logic     data_illegal,
	output logic     data_dirty
);

	asid_t      asid;
	logic       tlb_we;
	tlb_index_t tlb_windex;
	vpn2_t      tlb_wvpn2;
	asid_t      tlb_wasid;
	logic       tlb_wg;
	pfn_t       tlb_wpfn0;
	logic       tlb_wd0;
	logic       tlb_wv0;
	pfn_t       tlb_wpfn1;
	logic       tlb_wd1;
	logic       tlb_wv1;
	tlb_index_t tlb_rindex;
	vpn2_t      tlb_rvpn2;
	asid_t      tlb_rasid;
	logic       tlb_rg;
	pfn_t       tlb_rpfn0;
	logic       tlb_rd0;
	logic       tlb_rv0;
	pfn_t       tlb_rpfn1;
	logic       tlb_rd1;
	logic       tlb_rv1;
	vpn2_t      probe_vpn2;
	asid_t      probe_asid;
	logic       probe_hit;
	tlb_index_t probe_index;

	tlb_regs u_tlb_regs (
		.clk, .arst_n,
		.cp0_we, .cp0_sel, .cp0_wdata, .cp0_rdata,
		.tlbr, .tlbwi, .tlbwr, .tlbp,
		.asid,
		.tlb_we, .tlb_windex, .tlb_wvpn2, .tlb_wasid, .tlb_wg,
		.tlb_wpfn0, .tlb_wd0, .tlb_wv0, .tlb_wpfn1, .tlb_wd1, .tlb_wv1,
		.tlb_rindex, .tlb_rvpn2, .tlb_rasid, .tlb_rg,
		.tlb_rpfn0, .tlb_rd0, .tlb_rv0, .tlb_rpfn1, .tlb_rd1, .tlb_rv1,
		.probe_vpn2, .probe_asid, .probe_hit, .probe_index
	);

	mmu #(
		.mmu_enabled (mmu_enabled)
	) u_mmu (
		.clk, .arst_n,
		.asid, .is_user_mode, .inst_vaddr, .data_vaddr,
		.tlb_we, .tlb_windex, .tlb_wvpn2, .tlb_wasid, .tlb_wg,
		.tlb_wpfn0, .tlb_wd0, .tlb_wv0, .tlb_wpfn1, .tlb_wd1, .tlb_wv1,
		.tlb_rindex, .tlb_rvpn2, .tlb_rasid, .tlb_rg,
		.tlb_rpfn0, .tlb_rd0, .tlb_rv0, .tlb_rpfn1, .tlb_rd1, .tlb_rv1,
		.probe_vpn2, .probe_asid, .probe_hit, .probe_index,
		.inst_phy_addr, .inst_miss, .inst_invalid, .inst_illegal,
		.data_phy_addr, .data_miss, .data_invalid, .data_illegal, .data_dirty
	);

endmodule

//--- sim/tb_mmu_top.sv
`timescale 1ns/1ps

module tb_mmu_top
	import mmu_pkg::*;
;

	localparam int CLK_PERIOD_NS = 4;
	localparam int TIMEOUT_NS    = CLK_PERIOD_NS * 5000; // Far more cycles than all tests use.

	localparam int OP_TLBR  = 0;
	localparam int OP_TLBWI = 1;
	localparam int OP_TLBWR = 2;
	localparam int OP_TLBP  = 3;

	logic     clk = 1'b0;
	logic     arst_n;
	logic     is_user_mode;
	vaddr_t   inst_vaddr;
	vaddr_t   data_vaddr;
	logic     cp0_we;
	cp0_sel_t cp0_sel;
	word_t    cp0_wdata;
	word_t    cp0_rdata;
	logic     tlbr;
	logic     tlbwi;
	logic     tlbwr;
	logic     tlbp;
	paddr_t   inst_phy_addr;
	logic     inst_miss;
	logic     inst_invalid;
	logic     inst_illegal;
	paddr_t   data_phy_addr;
	logic     data_miss;
	logic     data_invalid;
	logic     data_illegal;
	logic     data_dirty;

	int    errors = 0;
	int    checks = 0;
	int    edges_since_reset = 0;
	word_t lcg_state = 32'd97;

	mmu_top DUT (.*);

	always #(CLK_PERIOD_NS / 2) clk = ~clk;

	// Counts the rising edges that Random has seen since reset was released.
	always @(posedge clk)
	begin
		if (arst_n)
			edges_since_reset <= edges_since_reset + 1;
	end

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Random starts at 15 and counts down once per edge, wrapping from 0 to 15.
	function automatic tlb_index_t random_after(input int edges);
		return tlb_index_t'(15 - edges % 16);
	endfunction

	// EntryHi and EntryLo layouts as software sees them.
	function automatic word_t hi_word(input vpn2_t vpn2, input asid_t id);
		return {vpn2, 5'b00000, id};
	endfunction

	function automatic word_t lo_word(input pfn_t pfn, input logic d, input logic v, input logic g);
		return {6'b000000, pfn, 3'b000, d, v, g};
	endfunction

	task automatic compare_addr(input string what, input paddr_t got, input paddr_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_word(input string what, input word_t got, input word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic cp0_write(input cp0_sel_t sel, input word_t data);
		@(posedge clk);
		cp0_we    <= 1'b1;
		cp0_sel   <= sel;
		cp0_wdata <= data;
		@(posedge clk);
		cp0_we <= 1'b0;
	endtask

	task automatic cp0_read(input cp0_sel_t sel, output word_t data);
		@(posedge clk);
		cp0_sel <= sel;
		@(negedge clk);
		data = cp0_rdata;
	endtask

	task automatic pulse_op(input int op);
		@(posedge clk);
		case (op)
			OP_TLBR:  tlbr  <= 1'b1;
			OP_TLBWI: tlbwi <= 1'b1;
			OP_TLBWR: tlbwr <= 1'b1;
			default:  tlbp  <= 1'b1;
		endcase
		@(posedge clk);
		tlbr  <= 1'b0;
		tlbwi <= 1'b0;
		tlbwr <= 1'b0;
		tlbp  <= 1'b0;
	endtask

	// Results are sampled on the falling edge, half a cycle after the inputs settle.
	task automatic lookup(input vaddr_t iva, input vaddr_t dva, input logic user);
		@(posedge clk);
		inst_vaddr   <= iva;
		data_vaddr   <= dva;
		is_user_mode <= user;
		@(negedge clk);
	endtask

	task automatic load_entry_regs(input vpn2_t vpn2, input asid_t id, input logic g,
		input pfn_t pfn0, input logic d0, input logic v0,
		input pfn_t pfn1, input logic d1, input logic v1);
		cp0_write(CP0_ENTRY_HI, hi_word(vpn2, id));
		cp0_write(CP0_ENTRY_LO0, lo_word(pfn0, d0, v0, g));
		cp0_write(CP0_ENTRY_LO1, lo_word(pfn1, d1, v1, g));
	endtask

	task automatic write_indexed(input tlb_index_t idx, input vpn2_t vpn2, input asid_t id,
		input logic g, input pfn_t pfn0, input logic d0, input logic v0,
		input pfn_t pfn1, input logic d1, input logic v1);
		load_entry_regs(vpn2, id, g, pfn0, d0, v0, pfn1, d1, v1);
		cp0_write(CP0_INDEX, {28'd0, idx});
		pulse_op(OP_TLBWI);
	endtask

	task automatic expect_inst(input paddr_t addr, input logic miss, input logic illegal);
		compare_addr("inst_phy_addr", inst_phy_addr, addr);
		compare_flag("inst_miss", inst_miss, miss);
		compare_flag("inst_illegal", inst_illegal, illegal);
	endtask

	task automatic expect_data(input paddr_t addr, input logic miss, input logic illegal,
		input logic dirty);
		compare_addr("data_phy_addr", data_phy_addr, addr);
		compare_flag("data_miss", data_miss, miss);
		compare_flag("data_illegal", data_illegal, illegal);
		compare_flag("data_dirty", data_dirty, dirty);
	endtask

	task automatic unmapped_segments();
		lookup(32'h8001_2345, 32'hA00F_F0F0, 1'b0); // kseg0 and kseg1.
		expect_inst(32'h0001_2345, 1'b0, 1'b0);
		expect_data(32'h000F_F0F0, 1'b0, 1'b0, 1'b1);
		compare_flag("inst_invalid", inst_invalid, 1'b0);
		compare_flag("data_invalid", data_invalid, 1'b0);
		lookup(32'hBFC0_0000, 32'h9FFF_FFFC, 1'b0);
		expect_inst(32'h1FC0_0000, 1'b0, 1'b0);
		expect_data(32'h1FFF_FFFC, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic write_then_lookup();
		write_indexed(4'd3, 19'h00400, 8'h11, 1'b0,
			20'h12345, 1'b1, 1'b1, 20'hABCDE, 1'b0, 1'b1);
		lookup({19'h00400, 1'b0, 12'h678}, {19'h00400, 1'b1, 12'h9AB}, 1'b0);
		expect_inst({20'h12345, 12'h678}, 1'b0, 1'b0);
		expect_data({20'hABCDE, 12'h9AB}, 1'b0, 1'b0, 1'b0);
		lookup({19'h00400, 1'b1, 12'h004}, {19'h00400, 1'b0, 12'hFF0}, 1'b0);
		expect_inst({20'hABCDE, 12'h004}, 1'b0, 1'b0);
		expect_data({20'h12345, 12'hFF0}, 1'b0, 1'b0, 1'b1);

		// The even page of this pair is not valid.
		write_indexed(4'd5, 19'h00600, 8'h11, 1'b0,
			20'h0F0F0, 1'b0, 1'b0, 20'h0A0A0, 1'b1, 1'b1);
		lookup({19'h00600, 1'b1, 12'h100}, {19'h00600, 1'b0, 12'h200}, 1'b0);
		expect_inst({20'h0A0A0, 12'h100}, 1'b0, 1'b0);
		compare_flag("data_miss", data_miss, 1'b0);
		compare_flag("data_illegal", data_illegal, 1'b1);
	endtask

	task automatic asid_and_global();
		write_indexed(4'd7, 19'h00500, 8'h33, 1'b1,
			20'h55555, 1'b0, 1'b1, 20'h66666, 1'b1, 1'b1);
		cp0_write(CP0_ENTRY_HI, hi_word(19'h00000, 8'h44));
		lookup({19'h00400, 1'b0, 12'h678}, {19'h00500, 1'b0, 12'h010}, 1'b0);
		compare_flag("inst_miss", inst_miss, 1'b1);
		compare_flag("inst_illegal", inst_illegal, 1'b1);
		expect_data({20'h55555, 12'h010}, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic probe_and_read();
		word_t rd;
		cp0_write(CP0_ENTRY_HI, hi_word(19'h00400, 8'h11));
		cp0_write(CP0_INDEX, 32'd0);
		pulse_op(OP_TLBP);
		cp0_read(CP0_INDEX, rd);
		compare_word("Index after hit probe", rd, 32'h0000_0003);

		cp0_write(CP0_ENTRY_HI, hi_word(19'h70000, 8'h11));
		pulse_op(OP_TLBP);
		cp0_read(CP0_INDEX, rd);
		compare_word("Index after failed probe", rd, 32'h8000_0003);

		cp0_write(CP0_INDEX, 32'd5);
		pulse_op(OP_TLBR);
		cp0_read(CP0_ENTRY_HI, rd);
		compare_word("EntryHi after TLBR", rd, hi_word(19'h00600, 8'h11));
		cp0_read(CP0_ENTRY_LO0, rd);
		compare_word("EntryLo0 after TLBR", rd, lo_word(20'h0F0F0, 1'b0, 1'b0, 1'b0));
		cp0_read(CP0_ENTRY_LO1, rd);
		compare_word("EntryLo1 after TLBR", rd, lo_word(20'h0A0A0, 1'b1, 1'b1, 1'b0));
	endtask

	task automatic user_mode_access();
		lookup(32'h0080_0678, 32'h8000_1000, 1'b1);
		compare_flag("inst_invalid", inst_invalid, 1'b0);
		compare_flag("data_invalid", data_invalid, 1'b1);
		lookup(32'hC000_0000, 32'h0000_1000, 1'b1);
		compare_flag("inst_invalid", inst_invalid, 1'b1);
		compare_flag("data_invalid", data_invalid, 1'b0);
		lookup(32'hC000_0000, 32'h8000_1000, 1'b0);
		compare_flag("inst_invalid", inst_invalid, 1'b0);
		compare_flag("data_invalid", data_invalid, 1'b0);
	endtask

	task automatic random_write();
		word_t      r;
		word_t      rd;
		vpn2_t      vpn2;
		asid_t      id;
		pfn_t       pfn0;
		pfn_t       pfn1;
		logic       d0;
		logic       d1;
		tlb_index_t widx;
		r    = lcg_next();
		vpn2 = {4'b0110, r[14:0]}; // Keeps clear of the pairs written earlier.
		id   = r[22:15];
		r    = lcg_next();
		pfn0 = r[19:0];
		d0   = r[20];
		r    = lcg_next();
		pfn1 = r[19:0];
		d1   = r[20];
		load_entry_regs(vpn2, id, 1'b0, pfn0, d0, 1'b1, pfn1, d1, 1'b1);
		pulse_op(OP_TLBWR);
		widx = random_after(edges_since_reset); // Count still stands before the strobe edge.
		cp0_read(CP0_RANDOM, rd);
		compare_word("Random after TLBWR", rd, {28'd0, random_after(edges_since_reset)});
		pulse_op(OP_TLBP);
		cp0_read(CP0_INDEX, rd);
		compare_word("Index after probe of TLBWR pair", rd, {28'd0, widx});
		lookup({vpn2, 1'b0, 12'h234}, {vpn2, 1'b1, 12'hFFC}, 1'b0);
		expect_inst({pfn0, 12'h234}, 1'b0, 1'b0);
		expect_data({pfn1, 12'hFFC}, 1'b0, 1'b0, d1);
	endtask

	initial
	begin
		arst_n       = 1'b0;
		is_user_mode = 1'b0;
		inst_vaddr   = '0;
		data_vaddr   = '0;
		cp0_we       = 1'b0;
		cp0_sel      = CP0_INDEX;
		cp0_wdata    = '0;
		tlbr         = 1'b0;
		tlbwi        = 1'b0;
		tlbwr        = 1'b0;
		tlbp         = 1'b0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		unmapped_segments();
		write_then_lookup();
		asid_and_global();
		probe_and_read();
		user_mode_access();
		random_write();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- mips_mmu.f
+incdir+source
source/mmu_pkg.sv
source/tlb.sv
source/mmu.sv
source/tlb_regs.sv
source/mmu_top.sv
sim/tb_mmu_top.sv

//--- Makefile
TOP  := tb_mmu_top
SRCS := $(wildcard source/*.sv source/*.svh sim/*.sv)

obj_dir/V$(TOP): mips_mmu.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f mips_mmu.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
